// ==== source/msi_walk_config.svh ====
// MSI walker configuration
`ifndef MSI_WALK_CONFIG_SVH
`define MSI_WALK_CONFIG_SVH

// Address and page widths
`define MSI_XLEN        64
`define MSI_PLEN        56
`define MSI_PPN_W       44
`define MSI_PGOFF_W     12
// Guest page number, guest address of 41 bits
`define MSI_GPPN_W      29

// One read beat, half of an MSI PTE
`define MSI_BEAT_W      64

// MRIF cache entry fields
`define MSI_MRIF_ADDR_W 47
`define MSI_NID_W       11

// Fault cause codes
`define MSI_CAUSE_W             12
`define MSI_CAUSE_NONE          12'd0
`define MSI_CAUSE_INSTR_ACCESS  12'd1
`define MSI_CAUSE_PTE_INVALID   12'd262
`define MSI_CAUSE_PTE_MISCONF   12'd263
`define MSI_CAUSE_DATA_CORRUPT  12'd270

`endif

// ==== source/msi_pte_pkg.sv ====
// MSI PTE formats and cause codes
`default_nettype none

`include "msi_walk_config.svh"

package msi_pte_pkg;

    // Raw read beat
    typedef logic [`MSI_BEAT_W-1:0] msi_beat_t;

    // PTE mode field, 0 and 2 reserved
    typedef enum logic [1:0] {
        MODE_MRIF = 2'd1,
        MODE_FLAT = 2'd3
    } msi_mode_e;

    typedef enum logic [`MSI_CAUSE_W-1:0] {
        CAUSE_NONE                   = `MSI_CAUSE_NONE,
        CAUSE_INSTR_ACCESS_FAULT     = `MSI_CAUSE_INSTR_ACCESS,
        CAUSE_MSI_PTE_INVALID        = `MSI_CAUSE_PTE_INVALID,
        CAUSE_MSI_PTE_MISCONFIGURED  = `MSI_CAUSE_PTE_MISCONF,
        CAUSE_MSI_PT_DATA_CORRUPTION = `MSI_CAUSE_DATA_CORRUPT
    } msi_cause_e;

    // Flat mode, first dword
    typedef struct packed {
        logic                  c;
        logic [8:0]            rsv_hi;
        logic [`MSI_PPN_W-1:0] ppn;
        logic [6:0]            rsv_lo;
        msi_mode_e             m;
        logic                  v;
    } msi_pte_flat_t;

    // MRIF mode, first dword
    typedef struct packed {
        logic                        c;
        logic [8:0]                  rsv_hi;
        logic [`MSI_MRIF_ADDR_W-1:0] addr;
        logic [3:0]                  rsv_lo;
        msi_mode_e                   m;
        logic                        v;
    } msi_pte_mrif_t;

    // MRIF mode, second dword
    // NID is split, bit 10 sits high
    typedef struct packed {
        logic [2:0]            rsv_hi;
        logic                  nid_10;
        logic [5:0]            rsv_lo;
        logic [`MSI_PPN_W-1:0] nppn;
        logic [9:0]            nid_lo;
    } msi_pte_notice_t;

    // MRIF cache update content
    typedef struct packed {
        logic [`MSI_MRIF_ADDR_W-1:0] addr;
        logic [`MSI_PPN_W-1:0]       nppn;
        logic [`MSI_NID_W-1:0]       nid;
    } mrif_entry_t;

endpackage

`default_nettype wire

// ==== source/msi_walk_pkg.sv ====
// MSI walk request and verdict types
`default_nettype none

`include "msi_walk_config.svh"

package msi_walk_pkg;

    import msi_pte_pkg::*;

    // Walk request, sampled with the start strobe
    typedef struct packed {
        logic [`MSI_XLEN-1:0]   iova;
        // Read-for-execute
        logic                   rx;
        // MSI page table base
        logic [`MSI_PPN_W-1:0]  base_ppn;
        logic [`MSI_GPPN_W-1:0] addr_mask;
    } walk_req_t;

    // Walk outcome, exactly one per walk
    typedef enum logic [1:0] {
        IOTLB_UPDATE = 2'd0,
        MRIFC_UPDATE = 2'd1,
        IGNORE       = 2'd2,
        FAULT        = 2'd3
    } outcome_e;

    // Shared by both checkers and the result port
    typedef struct packed {
        outcome_e      outcome;
        msi_cause_e    cause;
        msi_pte_flat_t flat_pte;
        mrif_entry_t   mrif;
    } verdict_t;

    // Flat walker FSM
    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        FETCH      = 2'd1,
        FIRST_BEAT = 2'd2,
        DRAIN      = 2'd3
    } flat_state_e;

    // MRIF checker FSM
    typedef enum logic {
        WAIT_TRIGGER = 1'b0,
        NOTICE_BEAT  = 1'b1
    } mrif_state_e;

endpackage

`default_nettype wire

// ==== source/msi_flat_walker.sv ====
// MSI PTE fetch and flat check
`default_nettype none

`include "msi_walk_config.svh"

module msi_flat_walker (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // Walk start
    input  logic                    start_i,
    input  msi_walk_pkg::walk_req_t req_i,
    // PTE read
    output logic                    rd_req_o,
    output logic [`MSI_PLEN-1:0]    rd_addr_o,
    input  logic                    beat_valid_i,
    input  msi_pte_pkg::msi_beat_t  beat_data_i,
    input  logic                    beat_err_i,
    input  logic                    beat_last_i,
    // Flat verdict
    output logic                    flat_valid_o,
    output msi_walk_pkg::verdict_t  flat_verdict_o,
    // Hand-off to MRIF checker
    output logic                    mrif_trigger_o,
    output logic [`MSI_PGOFF_W-1:0] iova_low_o,
    output logic                    busy_o
);
    import msi_pte_pkg::*;
    import msi_walk_pkg::*;

    flat_state_e             state_q, state_n;
    logic                    accept;
    logic                    rx_q;
    logic [`MSI_PLEN-1:0]    pptr_q;
    logic [`MSI_PGOFF_W-1:0] iova_low_q;
    logic [`MSI_GPPN_W-1:0]  if_num;
    msi_pte_flat_t           pte;
    logic                    fault;
    msi_cause_e              fault_cause;

    // Pack guest page bits where the mask is clear, low end first
    function automatic logic [`MSI_GPPN_W-1:0] extract_if_num(
        input logic [`MSI_GPPN_W-1:0] gppn,
        input logic [`MSI_GPPN_W-1:0] mask
    );
        logic [`MSI_GPPN_W-1:0] num;
        logic [4:0]             k;
        num = '0;
        k   = '0;
        for (int i = 0; i < `MSI_GPPN_W; i++) begin
            if (!mask[i]) begin
                num[k] = gppn[i];
                k      = k + 5'd1;
            end
        end
        return num;
    endfunction

    // Start only from idle
    assign accept = start_i && (state_q == IDLE);
    // Guest page is IOVA 40:12
    assign if_num = extract_if_num(
        req_i.iova[`MSI_GPPN_W+`MSI_PGOFF_W-1:`MSI_PGOFF_W], req_i.addr_mask);
    assign pte = beat_data_i;

    always_comb begin
        state_n        = state_q;
        rd_req_o       = 1'b0;
        mrif_trigger_o = 1'b0;
        fault          = 1'b0;
        fault_cause    = CAUSE_NONE;
        flat_valid_o   = 1'b0;
        flat_verdict_o = '0;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_n = FETCH;
                end
            end
            FETCH: begin
                // Read-for-execute never reaches memory
                if (rx_q) begin
                    fault       = 1'b1;
                    fault_cause = CAUSE_INSTR_ACCESS_FAULT;
                    state_n     = IDLE;
                end else begin
                    rd_req_o = 1'b1;
                    state_n  = FIRST_BEAT;
                end
            end
            FIRST_BEAT: begin
                if (beat_valid_i) begin
                    // Second beat is always drained here
                    state_n = DRAIN;
                    // Custom format (C set) treated as invalid
                    if (!pte.v || pte.c) begin
                        fault       = 1'b1;
                        fault_cause = CAUSE_MSI_PTE_INVALID;
                    end else if (beat_err_i) begin
                        fault       = 1'b1;
                        fault_cause = CAUSE_MSI_PT_DATA_CORRUPTION;
                    end else begin
                        case (pte.m)
                            MODE_MRIF: mrif_trigger_o = 1'b1;
                            MODE_FLAT: begin
                                if ((|pte.rsv_lo) || (|pte.rsv_hi)) begin
                                    fault       = 1'b1;
                                    fault_cause = CAUSE_MSI_PTE_MISCONFIGURED;
                                end else begin
                                    flat_valid_o            = 1'b1;
                                    flat_verdict_o.outcome  = IOTLB_UPDATE;
                                    flat_verdict_o.flat_pte = pte;
                                end
                            end
                            // Reserved modes
                            default: begin
                                fault       = 1'b1;
                                fault_cause = CAUSE_MSI_PTE_MISCONFIGURED;
                            end
                        endcase
                    end
                end
            end
            DRAIN: begin
                if (beat_valid_i && beat_last_i) begin
                    state_n = IDLE;
                end
            end
            default: state_n = IDLE;
        endcase
        if (fault) begin
            flat_valid_o           = 1'b1;
            flat_verdict_o.outcome = FAULT;
            flat_verdict_o.cause   = fault_cause;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            rx_q    <= 1'b0;
        end else begin
            state_q <= state_n;
            if (accept) begin
                rx_q <= req_i.rx;
            end
        end
    end

    // PTE address is base | (if_num << 4), 16-byte entries
    always_ff @(posedge clk_i) begin
        if (accept) begin
            pptr_q     <= {req_i.base_ppn, {`MSI_PGOFF_W{1'b0}}}
                        | ({{(`MSI_PLEN-`MSI_GPPN_W){1'b0}}, if_num} << 4);
            iova_low_q <= req_i.iova[`MSI_PGOFF_W-1:0];
        end
    end

    assign rd_addr_o  = pptr_q;
    assign iova_low_o = iova_low_q;
    assign busy_o     = (state_q != IDLE);

endmodule

`default_nettype wire

// ==== source/msi_mrif_checker.sv ====
// MRIF mode PTE check
`default_nettype none

`include "msi_walk_config.svh"

module msi_mrif_checker (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // From flat walker, same cycle as first beat
    input  logic                    mrif_trigger_i,
    input  logic [`MSI_PGOFF_W-1:0] iova_low_i,
    // Read beats
    input  logic                    beat_valid_i,
    input  msi_pte_pkg::msi_beat_t  beat_data_i,
    input  logic                    beat_err_i,
    // MRIF verdict
    output logic                    mrif_valid_o,
    output msi_walk_pkg::verdict_t  mrif_verdict_o,
    output logic                    busy_o
);
    import msi_pte_pkg::*;
    import msi_walk_pkg::*;

    mrif_state_e                 state_q, state_n;
    logic                        load_addr;
    logic [`MSI_MRIF_ADDR_W-1:0] addr_q;
    msi_pte_mrif_t               pte_mrif;
    msi_pte_notice_t             notice;

    // Same beat bus, two views
    assign pte_mrif = beat_data_i;
    assign notice   = beat_data_i;

    always_comb begin
        state_n        = state_q;
        load_addr      = 1'b0;
        mrif_valid_o   = 1'b0;
        mrif_verdict_o = '0;
        case (state_q)
            WAIT_TRIGGER: begin
                if (mrif_trigger_i) begin
                    if ((|pte_mrif.rsv_lo) || (|pte_mrif.rsv_hi)) begin
                        mrif_valid_o           = 1'b1;
                        mrif_verdict_o.outcome = FAULT;
                        mrif_verdict_o.cause   = CAUSE_MSI_PTE_MISCONFIGURED;
                    end else if (|iova_low_i) begin
                        // Non-aligned access, dropped without fault
                        mrif_valid_o           = 1'b1;
                        mrif_verdict_o.outcome = IGNORE;
                    end else begin
                        load_addr = 1'b1;
                        state_n   = NOTICE_BEAT;
                    end
                end
            end
            NOTICE_BEAT: begin
                if (beat_valid_i) begin
                    mrif_valid_o = 1'b1;
                    state_n      = WAIT_TRIGGER;
                    if (beat_err_i) begin
                        mrif_verdict_o.outcome = FAULT;
                        mrif_verdict_o.cause   = CAUSE_MSI_PT_DATA_CORRUPTION;
                    end else if ((|notice.rsv_lo) || (|notice.rsv_hi)) begin
                        mrif_verdict_o.outcome = FAULT;
                        mrif_verdict_o.cause   = CAUSE_MSI_PTE_MISCONFIGURED;
                    end else begin
                        mrif_verdict_o.outcome   = MRIFC_UPDATE;
                        mrif_verdict_o.mrif.addr = addr_q;
                        mrif_verdict_o.mrif.nppn = notice.nppn;
                        // Rejoin the split notice ID
                        mrif_verdict_o.mrif.nid  = {notice.nid_10, notice.nid_lo};
                    end
                end
            end
            default: state_n = WAIT_TRIGGER;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= WAIT_TRIGGER;
        end else begin
            state_q <= state_n;
        end
    end

    // MRIF address held until the notice beat
    always_ff @(posedge clk_i) begin
        if (load_addr) begin
            addr_q <= pte_mrif.addr;
        end
    end

    assign busy_o = (state_q == NOTICE_BEAT);

endmodule

`default_nettype wire

// ==== source/msi_result_merge.sv ====
// Walk verdict merge
`default_nettype none

module msi_result_merge (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flat_valid_i,
    input  msi_walk_pkg::verdict_t flat_verdict_i,
    input  logic                   mrif_valid_i,
    input  msi_walk_pkg::verdict_t mrif_verdict_i,
    input  logic                   flat_busy_i,
    input  logic                   mrif_busy_i,
    output logic                   done_o,
    output msi_walk_pkg::verdict_t result_o,
    output logic                   busy_o
);
    import msi_pte_pkg::*;
    import msi_walk_pkg::*;

    // Result shown before any walk
    localparam verdict_t result_init = '{
        outcome:  IGNORE,
        cause:    CAUSE_NONE,
        flat_pte: '0,
        mrif:     '0
    };

    // At most one strobe per walk, flat checked first
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            done_o   <= 1'b0;
            result_o <= result_init;
        end else begin
            done_o <= flat_valid_i | mrif_valid_i;
            if (flat_valid_i) begin
                result_o <= flat_verdict_i;
            end else if (mrif_valid_i) begin
                result_o <= mrif_verdict_i;
            end
        end
    end

    // Walk ends when both sides are idle
    assign busy_o = flat_busy_i | mrif_busy_i;

endmodule

`default_nettype wire

// ==== source/msi_ptw.sv ====
// MSI page-table walker
`default_nettype none

`include "msi_walk_config.svh"

module msi_ptw (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // Walk start
    input  logic                    start_i,
    input  msi_walk_pkg::walk_req_t req_i,
    // Memory read
    output logic                    rd_req_o,
    output logic [`MSI_PLEN-1:0]    rd_addr_o,
    input  logic                    beat_valid_i,
    input  msi_pte_pkg::msi_beat_t  beat_data_i,
    input  logic                    beat_err_i,
    input  logic                    beat_last_i,
    // Result
    output logic                    done_o,
    output msi_walk_pkg::verdict_t  result_o,
    output logic                    busy_o
);
    import msi_walk_pkg::*;

    logic                    flat_valid;
    logic                    mrif_valid;
    logic                    mrif_trigger;
    logic                    flat_busy;
    logic                    mrif_busy;
    logic [`MSI_PGOFF_W-1:0] iova_low;
    verdict_t                flat_verdict;
    verdict_t                mrif_verdict;

    // Fetch and first-dword check
    msi_flat_walker i_flat_walker (
        .clk_i,
        .rst_ni,
        .start_i,
        .req_i,
        .rd_req_o,
        .rd_addr_o,
        .beat_valid_i,
        .beat_data_i,
        .beat_err_i,
        .beat_last_i,
        .flat_valid_o   (flat_valid),
        .flat_verdict_o (flat_verdict),
        .mrif_trigger_o (mrif_trigger),
        .iova_low_o     (iova_low),
        .busy_o         (flat_busy)
    );

    // MRIF path runs beside the flat walker
    msi_mrif_checker i_mrif_checker (
        .clk_i,
        .rst_ni,
        .mrif_trigger_i (mrif_trigger),
        .iova_low_i     (iova_low),
        .beat_valid_i,
        .beat_data_i,
        .beat_err_i,
        .mrif_valid_o   (mrif_valid),
        .mrif_verdict_o (mrif_verdict),
        .busy_o         (mrif_busy)
    );

    msi_result_merge i_result_merge (
        .clk_i,
        .rst_ni,
        .flat_valid_i   (flat_valid),
        .flat_verdict_i (flat_verdict),
        .mrif_valid_i   (mrif_valid),
        .mrif_verdict_i (mrif_verdict),
        .flat_busy_i    (flat_busy),
        .mrif_busy_i    (mrif_busy),
        .done_o,
        .result_o,
        .busy_o
    );

endmodule

`default_nettype wire

// ==== verif/msi_ptw_assert.sv ====
// MSI PTW protocol assertions
`default_nettype none

module msi_ptw_assert (
    input logic clk_i,
    input logic rst_ni,
    input logic done_o,
    input logic rd_req_o,
    input logic busy_o
);

    // One cycle result strobe
    done_single: assert property (
        @(posedge clk_i) disable iff (!rst_ni) done_o |=> !done_o)
        else $error("done_o high in two consecutive cycles");

    // Reads only inside a walk
    read_in_walk: assert property (
        @(posedge clk_i) disable iff (!rst_ni) rd_req_o |-> busy_o)
        else $error("rd_req_o while busy_o is low");

    // Single read strobe per fetch
    read_single: assert property (
        @(posedge clk_i) disable iff (!rst_ni) rd_req_o |=> !rd_req_o)
        else $error("rd_req_o high in two consecutive cycles");

    // Idle when leaving reset
    reset_idle: assert property (
        @(posedge clk_i) $rose(rst_ni) |-> (!busy_o && !done_o && !rd_req_o))
        else $error("walker not idle after reset");

endmodule

`default_nettype wire

// ==== verif/msi_ptw_tb.sv ====
// MSI PTW testbench
`default_nettype none

`include "msi_walk_config.svh"

module msi_ptw_tb;
    import msi_pte_pkg::*;
    import msi_walk_pkg::*;

    // Walks per test
    localparam int N_FLAT    = 20;
    localparam int N_BAD     = 12;
    localparam int N_RX      = 4;
    localparam int N_MRIF    = 12;
    localparam int N_IGNORE  = 4;
    localparam int N_BUSERR  = 8;
    localparam int NUM_WALKS = N_FLAT + N_BAD + N_RX + N_MRIF + N_IGNORE + N_BUSERR;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   start_i;
    walk_req_t              req_i;
    logic                   rd_req_o;
    logic [`MSI_PLEN-1:0]   rd_addr_o;
    logic                   beat_valid_i;
    logic [`MSI_BEAT_W-1:0] beat_data_i;
    logic                   beat_err_i;
    logic                   beat_last_i;
    logic                   done_o;
    verdict_t               result_o;
    logic                   busy_o;

    integer seed = 32'hfc98;
    int     errors = 0;
    int     walk_cnt = 0;
    int     cyc = 0;

    // Current walk, set up before its start
    walk_req_t            cur_req;
    logic [63:0]          beat_tbl [2];
    logic                 err_tbl [2];
    verdict_t             exp_v;
    logic [`MSI_PLEN-1:0] exp_addr;
    logic                 exp_notice;

    // Seen during the walk
    int   start_cyc;
    int   done_cnt;
    int   rd_cnt;
    int   mem_beats;
    int   beat_cyc [2];
    logic walk_end;
    logic busy_prev = 1'b0;

    msi_ptw i_dut (
        .clk_i,
        .rst_ni,
        .start_i,
        .req_i,
        .rd_req_o,
        .rd_addr_o,
        .beat_valid_i,
        .beat_data_i,
        .beat_err_i,
        .beat_last_i,
        .done_o,
        .result_o,
        .busy_o
    );

    bind msi_ptw msi_ptw_assert i_assert (.clk_i, .rst_ni, .done_o, .rd_req_o, .busy_o);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Cycle stamp, read only on falling edges
    initial begin
        forever begin
            @(posedge clk_i);
            cyc++;
        end
    end

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic walk_req_t rand_req(input logic rx);
        walk_req_t   r;
        logic [63:0] t;
        r.iova      = rand64();
        r.rx        = rx;
        t           = rand64();
        r.base_ppn  = t[43:0];
        r.addr_mask = t[63:35];
        return r;
    endfunction

    // Beat builders from the PTE bit layout
    function automatic logic [63:0] make_flat();
        logic [63:0] t;
        t = rand64();
        return {1'b0, 9'd0, t[43:0], 7'd0, 2'b11, 1'b1};
    endfunction

    function automatic logic [63:0] make_mrif();
        logic [63:0] t;
        t = rand64();
        return {1'b0, 9'd0, t[46:0], 4'd0, 2'b01, 1'b1};
    endfunction

    function automatic logic [63:0] make_notice();
        logic [63:0] t;
        t = rand64();
        return {3'd0, t[10], 6'd0, t[63:20], t[9:0]};
    endfunction

    // Unmasked guest page bits, packed from the low end
    function automatic logic [`MSI_PLEN-1:0] pte_address(input walk_req_t req);
        logic [`MSI_PLEN-1:0] num;
        int                   k;
        num = '0;
        k   = 0;
        for (int i = 0; i < `MSI_GPPN_W; i++) begin
            if (req.addr_mask[i] == 1'b0) begin
                num[k] = req.iova[12 + i];
                k++;
            end
        end
        return {req.base_ppn, 12'd0} | (num << 4);
    endfunction

    function automatic verdict_t expected_verdict(
        input walk_req_t   req,
        input logic [63:0] b0,
        input logic [63:0] b1,
        input logic        e0,
        input logic        e1
    );
        verdict_t v;
        v         = '0;
        v.outcome = FAULT;
        if (req.rx) begin
            v.cause = msi_cause_e'(12'd1);
        end else if (!b0[0] || b0[63]) begin
            v.cause = msi_cause_e'(12'd262);
        end else if (e0) begin
            v.cause = msi_cause_e'(12'd270);
        end else if (b0[2:1] == 2'd3) begin
            if ((|b0[9:3]) || (|b0[62:54])) begin
                v.cause = msi_cause_e'(12'd263);
            end else begin
                v.outcome  = IOTLB_UPDATE;
                v.flat_pte = b0;
            end
        end else if (b0[2:1] == 2'd1) begin
            if ((|b0[6:3]) || (|b0[62:54])) begin
                v.cause = msi_cause_e'(12'd263);
            end else if (|req.iova[11:0]) begin
                v.outcome = IGNORE;
            end else if (e1) begin
                v.cause = msi_cause_e'(12'd270);
            end else if ((|b1[59:54]) || (|b1[63:61])) begin
                v.cause = msi_cause_e'(12'd263);
            end else begin
                v.outcome   = MRIFC_UPDATE;
                v.mrif.addr = b0[53:7];
                v.mrif.nppn = b1[53:10];
                v.mrif.nid  = {b1[60], b1[9:0]};
            end
        end else begin
            // Modes 0 and 2
            v.cause = msi_cause_e'(12'd263);
        end
        return v;
    endfunction

    // True when the notice beat decides the walk
    function automatic logic notice_decides(
        input walk_req_t   req,
        input logic [63:0] b0,
        input logic        e0
    );
        return !req.rx && b0[0] && !b0[63] && !e0 && (b0[2:1] == 2'd1)
            && !(|b0[6:3]) && !(|b0[62:54]) && (req.iova[11:0] == 12'd0);
    endfunction

    task automatic report_value(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        errors++;
        $display("FAILED %s: got 0x%0h expected 0x%0h (walk %0d)", name, got, exp, walk_cnt);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("ERROR walk %0d: %s", walk_cnt, msg);
    endtask

    task automatic check_result();
        int exp_cyc;
        if (cur_req.rx) begin
            exp_cyc = start_cyc + 2;
        end else if (exp_notice) begin
            exp_cyc = beat_cyc[1] + 1;
        end else begin
            exp_cyc = beat_cyc[0] + 1;
        end
        if (cyc != exp_cyc) begin
            report_problem($sformatf("done_o at cycle %0d, expected %0d", cyc, exp_cyc));
        end
        if (result_o.outcome !== exp_v.outcome) begin
            report_value("result_o.outcome", 128'(result_o.outcome), 128'(exp_v.outcome));
        end else if (exp_v.outcome == FAULT && result_o.cause !== exp_v.cause) begin
            report_value("result_o.cause", 128'(result_o.cause), 128'(exp_v.cause));
        end else if (exp_v.outcome == IOTLB_UPDATE && result_o.flat_pte !== exp_v.flat_pte) begin
            report_value("result_o.flat_pte", 128'(result_o.flat_pte), 128'(exp_v.flat_pte));
        end else if (exp_v.outcome == MRIFC_UPDATE && result_o.mrif !== exp_v.mrif) begin
            report_value("result_o.mrif", 128'(result_o.mrif), 128'(exp_v.mrif));
        end
    endtask

    // Walk ends on the fall of busy_o
    task automatic check_end();
        if (cur_req.rx) begin
            if (cyc != start_cyc + 2) begin
                report_problem("busy_o did not fall together with done_o");
            end
        end else if (mem_beats != 2 || cyc != beat_cyc[1] + 1) begin
            report_problem("busy_o did not fall on the cycle after the second beat");
        end
    endtask

    // Compare process, samples on the falling edge
    initial begin
        forever begin
            @(negedge clk_i);
            if (rst_ni) begin
                if (rd_req_o) begin
                    rd_cnt++;
                    if (rd_addr_o !== exp_addr) begin
                        report_value("rd_addr_o", 128'(rd_addr_o), 128'(exp_addr));
                    end
                end
                if (done_o) begin
                    done_cnt++;
                    check_result();
                end
                if (busy_prev && !busy_o) begin
                    walk_end = 1'b1;
                    check_end();
                end
                busy_prev = busy_o;
            end
        end
    end

    task automatic send_beat(input int idx);
        beat_valid_i   = 1'b1;
        beat_data_i    = beat_tbl[idx];
        beat_err_i     = err_tbl[idx];
        beat_last_i    = (idx == 1);
        beat_cyc[idx]  = cyc;
        mem_beats++;
    endtask

    task automatic idle_beat();
        beat_valid_i = 1'b0;
        beat_data_i  = '0;
        beat_err_i   = 1'b0;
        beat_last_i  = 1'b0;
    endtask

    // Memory model, two beats per read with random delay and gap
    initial begin
        int delay;
        int gap;
        forever begin
            @(negedge clk_i);
            if (rst_ni && rd_req_o) begin
                delay = 1 + int'($unsigned($random(seed)) % 4);
                gap   = int'($unsigned($random(seed)) % 4);
                repeat (delay) @(negedge clk_i);
                send_beat(0);
                repeat (gap) begin
                    @(negedge clk_i);
                    idle_beat();
                end
                @(negedge clk_i);
                send_beat(1);
                @(negedge clk_i);
                idle_beat();
            end
        end
    end

    // One walk, called at a rising edge
    task automatic run_walk(input walk_req_t req, input logic [63:0] b0,
                            input logic [63:0] b1, input logic e0, input logic e1);
        cur_req     = req;
        beat_tbl[0] = b0;
        beat_tbl[1] = b1;
        err_tbl[0]  = e0;
        err_tbl[1]  = e1;
        exp_v       = expected_verdict(req, b0, b1, e0, e1);
        exp_addr    = pte_address(req);
        exp_notice  = notice_decides(req, b0, e0);
        done_cnt    = 0;
        rd_cnt      = 0;
        mem_beats   = 0;
        walk_end    = 1'b0;
        walk_cnt++;
        @(negedge clk_i);
        start_cyc = cyc;
        start_i   = 1'b1;
        req_i     = req;
        @(negedge clk_i);
        start_i = 1'b0;
        while (!walk_end) @(posedge clk_i);
        if (done_cnt != 1) begin
            report_problem($sformatf("%0d results instead of one", done_cnt));
        end
        if (rd_cnt != (req.rx ? 0 : 1)) begin
            report_problem($sformatf("%0d memory reads seen", rd_cnt));
        end
    endtask

    task automatic close_test(input string name, input int walks, input int err_start);
        $display("test %-12s walks %0d errors %0d", name, walks, errors - err_start);
    endtask

    task automatic test_flat_valid();
        int err_start;
        err_start = errors;
        for (int i = 0; i < N_FLAT; i++) begin
            run_walk(rand_req(1'b0), make_flat(), rand64(), 1'b0, 1'b0);
        end
        close_test("flat_valid", N_FLAT, err_start);
    endtask

    task automatic test_flat_bad();
        int          err_start;
        logic [63:0] b;
        logic [63:0] r;
        err_start = errors;
        for (int i = 0; i < N_BAD; i++) begin
            b = make_flat();
            r = rand64();
            case (i % 6)
                // V low, a reserved bit must not win
                0: begin
                    b[0] = 1'b0;
                    b[4] = r[0];
                end
                1: b[63] = 1'b1;
                2: b[3 + int'(r[7:0] % 7)] = 1'b1;
                3: b[54 + int'(r[7:0] % 9)] = 1'b1;
                4: b[2:1] = 2'b00;
                default: b[2:1] = 2'b10;
            endcase
            // Bus error loses to invalid
            run_walk(rand_req(1'b0), b, rand64(), (i % 6 < 2) && r[1], 1'b0);
        end
        close_test("flat_bad", N_BAD, err_start);
    endtask

    task automatic test_rx();
        int err_start;
        err_start = errors;
        for (int i = 0; i < N_RX; i++) begin
            run_walk(rand_req(1'b1), make_flat(), rand64(), 1'b0, 1'b0);
        end
        close_test("rx_fault", N_RX, err_start);
    endtask

    task automatic test_mrif();
        int          err_start;
        walk_req_t   req;
        logic [63:0] b0;
        logic [63:0] b1;
        logic [63:0] r;
        err_start = errors;
        for (int i = 0; i < N_MRIF; i++) begin
            req            = rand_req(1'b0);
            req.iova[11:0] = '0;
            b0             = make_mrif();
            b1             = make_notice();
            r              = rand64();
            case (i % 6)
                3: b0[3 + int'(r[7:0] % 4)] = 1'b1;
                4: b0[54 + int'(r[7:0] % 9)] = 1'b1;
                5: begin
                    if (r[8]) begin
                        b1[54 + int'(r[7:0] % 6)] = 1'b1;
                    end else begin
                        b1[61 + int'(r[7:0] % 3)] = 1'b1;
                    end
                end
                default: ;
            endcase
            run_walk(req, b0, b1, 1'b0, 1'b0);
        end
        close_test("mrif", N_MRIF, err_start);
    endtask

    task automatic test_ignore();
        int          err_start;
        walk_req_t   req;
        logic [63:0] t;
        err_start = errors;
        for (int i = 0; i < N_IGNORE; i++) begin
            req            = rand_req(1'b0);
            t              = rand64();
            req.iova[11:0] = (t[11:0] == 12'd0) ? 12'h800 : t[11:0];
            run_walk(req, make_mrif(), make_notice(), 1'b0, 1'b0);
        end
        close_test("mrif_ignore", N_IGNORE, err_start);
    endtask

    // Error walk, then a clean flat walk
    task automatic test_bus_err();
        int          err_start;
        walk_req_t   req;
        logic [63:0] b0;
        err_start = errors;
        for (int k = 0; k < N_BUSERR / 2; k++) begin
            req            = rand_req(1'b0);
            req.iova[11:0] = '0;
            b0             = (k == 0 || k == 3) ? make_flat() : make_mrif();
            run_walk(req, b0, make_notice(), k < 2, k >= 2);
            run_walk(rand_req(1'b0), make_flat(), rand64(), 1'b0, 1'b0);
        end
        close_test("bus_error", N_BUSERR, err_start);
    endtask

    initial begin
        rst_ni       = 1'b0;
        start_i      = 1'b0;
        req_i        = '0;
        beat_valid_i = 1'b0;
        beat_data_i  = '0;
        beat_err_i   = 1'b0;
        beat_last_i  = 1'b0;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        if (done_o || rd_req_o || busy_o) begin
            report_problem("outputs not idle during reset");
        end
        rst_ni = 1'b1;
        @(posedge clk_i);
        test_flat_valid();
        test_flat_bad();
        test_rx();
        test_mrif();
        test_ignore();
        test_bus_err();
        @(negedge clk_i);
        $display("tests 6 walks %0d errors %0d", walk_cnt, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog, 20 cycles per walk after reset
    initial begin
        repeat (10 + NUM_WALKS * 20) @(posedge clk_i);
        $display("ERROR watchdog expired before all walks finished");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+source
source/msi_pte_pkg.sv
source/msi_walk_pkg.sv
source/msi_flat_walker.sv
source/msi_mrif_checker.sv
source/msi_result_merge.sv
source/msi_ptw.sv
verif/msi_ptw_assert.sv
verif/msi_ptw_tb.sv

// ==== Makefile ====
TOP := msi_ptw_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
